// File: verilog.f
src/rename_pkg.sv
src/count_one.sv
src/free_list.sv
src/rename_map.sv
src/rename_unit.sv
testbench/rename_unit_properties.sv
testbench/clock_gen.sv
testbench/tb_rename_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the rename unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_rename_unit
BUILD_DIR=obj_dir
LOG_FILE=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" --Mdir "$BUILD_DIR" -f verilog.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q -F '*** FAILED ***' "$LOG_FILE"; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q -F '*** PASSED ***' "$LOG_FILE"; then
    echo "simulation ended without a verdict, exit status $sim_status"
    exit 1
fi
echo "simulation passed"
exit 0

// File: testbench/tb_rename_unit.sv
`timescale 1ns/1ps

module tb_rename_unit import rename_pkg::*; ();

    typedef enum logic [2:0] {
        OP_IDLE,
        OP_REN,
        OP_RND,
        OP_CMT,
        OP_RST
    } op_t;

    // aregs holds lane 0 in the low nibble
    typedef struct packed {
        op_t                     op;
        ren_mask_t               mask;
        logic [REN_WIDTH*4-1:0]  aregs;
        logic                    ready;
    } row_t;

    localparam int NUM_ROWS    = 32;
    localparam int WATCHDOG_NS = (NUM_ROWS + 20) * 10;

    logic      clk;
    logic      arst_n;
    logic      ren_vld;
    ren_mask_t ren_mask;
    areg_t     ren_areg [REN_WIDTH];
    logic      ren_ready;
    preg_t     ren_preg [REN_WIDTH];
    preg_t     ren_old_preg [REN_WIDTH];
    cmt_mask_t cmt_mask;
    areg_t     cmt_areg [CMT_WIDTH];
    preg_t     cmt_preg [CMT_WIDTH];
    preg_t     cmt_old_preg [CMT_WIDTH];
    logic      resteer;
    fl_count_t free_count;

    row_t stim [NUM_ROWS];

    // reference model
    preg_t free_q [$];
    preg_t spec_map [AREG_NUM];
    preg_t cmt_map [AREG_NUM];
    // renamed but not committed, oldest first
    areg_t fly_areg [$];
    preg_t fly_new [$];
    preg_t fly_old [$];

    integer seed;

    clock_gen u_clock_gen (
        .clk      (clk),
        .o_arst_n (arst_n)
    );

    rename_unit rename_unit_i (
        .clk            (clk),
        .i_arst_n       (arst_n),
        .i_ren_vld      (ren_vld),
        .i_ren_mask     (ren_mask),
        .i_ren_areg     (ren_areg),
        .o_ren_ready    (ren_ready),
        .o_ren_preg     (ren_preg),
        .o_ren_old_preg (ren_old_preg),
        .i_cmt_mask     (cmt_mask),
        .i_cmt_areg     (cmt_areg),
        .i_cmt_preg     (cmt_preg),
        .i_cmt_old_preg (cmt_old_preg),
        .i_resteer      (resteer),
        .o_free_count   (free_count)
    );

    bind rename_unit rename_unit_properties u_properties (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_ren_vld    (i_ren_vld),
        .i_ren_mask   (i_ren_mask),
        .i_cmt_mask   (i_cmt_mask),
        .i_resteer    (i_resteer),
        .i_ren_ready  (o_ren_ready),
        .i_free_count (o_free_count)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_preg(input string name, input preg_t got, input preg_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input fl_count_t got, input fl_count_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_ready(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic int lanes_in(input logic [REN_WIDTH-1:0] m);
        int n;
        n = 0;
        for (int i = 0; i < REN_WIDTH; i++) begin
            if (m[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    // op, mask, aregs, expected ready
    task automatic load_table();
        stim[0]  = '{OP_IDLE, 4'b0000, 16'h0000, 1'b1};
        stim[1]  = '{OP_REN,  4'b1111, 16'h4321, 1'b1};
        // repeated areg 1 inside one group
        stim[2]  = '{OP_REN,  4'b1111, 16'h1511, 1'b1};
        stim[3]  = '{OP_REN,  4'b0011, 16'h0021, 1'b1};
        stim[4]  = '{OP_RND,  4'b1111, 16'h0000, 1'b1};
        stim[5]  = '{OP_RND,  4'b1111, 16'h0000, 1'b1};
        stim[6]  = '{OP_RND,  4'b1111, 16'h0000, 1'b1};
        stim[7]  = '{OP_RND,  4'b1111, 16'h0000, 1'b1};
        stim[8]  = '{OP_REN,  4'b0111, 16'h0A98, 1'b1};
        // 3 free, 4 asked
        stim[9]  = '{OP_REN,  4'b1111, 16'hBCDE, 1'b0};
        stim[10] = '{OP_IDLE, 4'b0000, 16'h0000, 1'b1};
        stim[11] = '{OP_REN,  4'b0011, 16'h00FE, 1'b1};
        stim[12] = '{OP_REN,  4'b0011, 16'h0076, 1'b0};
        stim[13] = '{OP_CMT,  4'b1111, 16'h0000, 1'b1};
        stim[14] = '{OP_CMT,  4'b1111, 16'h0000, 1'b1};
        // pool drained, released registers come back in order
        stim[15] = '{OP_REN,  4'b1111, 16'h3210, 1'b1};
        stim[16] = '{OP_REN,  4'b0001, 16'h000C, 1'b1};
        stim[17] = '{OP_CMT,  4'b0011, 16'h0000, 1'b1};
        stim[18] = '{OP_RST,  4'b1111, 16'h4321, 1'b0};
        stim[19] = '{OP_IDLE, 4'b0000, 16'h0000, 1'b1};
        stim[20] = '{OP_REN,  4'b1111, 16'h0521, 1'b1};
        stim[21] = '{OP_RND,  4'b1111, 16'h0000, 1'b1};
        stim[22] = '{OP_CMT,  4'b0111, 16'h0000, 1'b1};
        stim[23] = '{OP_RND,  4'b1111, 16'h0000, 1'b1};
        stim[24] = '{OP_CMT,  4'b1111, 16'h0000, 1'b1};
        stim[25] = '{OP_RND,  4'b0111, 16'h0000, 1'b1};
        stim[26] = '{OP_RST,  4'b0000, 16'h0000, 1'b0};
        stim[27] = '{OP_REN,  4'b1111, 16'hFFEF, 1'b1};
        stim[28] = '{OP_CMT,  4'b0011, 16'h0000, 1'b1};
        stim[29] = '{OP_REN,  4'b1111, 16'hFFFF, 1'b1};
        stim[30] = '{OP_CMT,  4'b1111, 16'h0000, 1'b1};
        stim[31] = '{OP_IDLE, 4'b0000, 16'h0000, 1'b1};
    endtask

    task automatic model_reset();
        free_q.delete();
        fly_areg.delete();
        fly_new.delete();
        fly_old.delete();
        for (int i = 0; i < FL_DEPTH; i++) begin
            free_q.push_back(preg_t'(AREG_NUM + i));
        end
        for (int r = 0; r < AREG_NUM; r++) begin
            spec_map[r] = preg_t'(r);
            cmt_map[r]  = preg_t'(r);
        end
    endtask

    task automatic clear_inputs();
        ren_vld  = 1'b0;
        ren_mask = '0;
        resteer  = 1'b0;
        cmt_mask = '0;
        for (int i = 0; i < REN_WIDTH; i++) begin
            ren_areg[i] = '0;
        end
        for (int i = 0; i < CMT_WIDTH; i++) begin
            cmt_areg[i]     = '0;
            cmt_preg[i]     = '0;
            cmt_old_preg[i] = '0;
        end
    endtask

    // the oldest in-flight instructions retire
    task automatic drive_commit(input cmt_mask_t m);
        int n;
        n = lanes_in(m);
        if (n > fly_new.size()) begin
            fail_run("the table commits more instructions than are in flight");
        end
        cmt_mask = m;
        for (int i = 0; i < n; i++) begin
            cmt_areg[i]     = fly_areg[i];
            cmt_preg[i]     = fly_new[i];
            cmt_old_preg[i] = fly_old[i];
        end
    endtask

    task automatic drive_row(input row_t row);
        clear_inputs();
        case (row.op)
            OP_REN: begin
                ren_vld  = 1'b1;
                ren_mask = row.mask;
                for (int i = 0; i < REN_WIDTH; i++) begin
                    ren_areg[i] = areg_t'(row.aregs[4*i +: 4]);
                end
            end
            OP_RND: begin
                ren_vld  = 1'b1;
                ren_mask = row.mask;
                for (int i = 0; i < REN_WIDTH; i++) begin
                    ren_areg[i] = areg_t'($random(seed));
                end
            end
            OP_RST: begin
                resteer  = 1'b1;
                ren_vld  = (row.mask != '0);
                ren_mask = row.mask;
                for (int i = 0; i < REN_WIDTH; i++) begin
                    ren_areg[i] = areg_t'(row.aregs[4*i +: 4]);
                end
            end
            OP_CMT: drive_commit(cmt_mask_t'(row.mask));
            default: ;
        endcase
    endtask

    // each lane takes the next free register and sees the lanes before it
    task automatic rename_and_check();
        preg_t new_preg;
        preg_t old_preg;
        for (int i = 0; i < REN_WIDTH; i++) begin
            if (ren_mask[i]) begin
                new_preg = free_q.pop_front();
                old_preg = spec_map[ren_areg[i]];
                check_preg($sformatf("o_ren_preg[%0d]", i), ren_preg[i], new_preg);
                check_preg($sformatf("o_ren_old_preg[%0d]", i), ren_old_preg[i], old_preg);
                spec_map[ren_areg[i]] = new_preg;
                fly_areg.push_back(ren_areg[i]);
                fly_new.push_back(new_preg);
                fly_old.push_back(old_preg);
            end
        end
    endtask

    task automatic retire_commit();
        int n;
        areg_t a;
        preg_t p;
        n = lanes_in(cmt_mask);
        for (int i = 0; i < n; i++) begin
            a = fly_areg.pop_front();
            p = fly_new.pop_front();
            cmt_map[a] = p;
            free_q.push_back(fly_old.pop_front());
        end
    endtask

    // in-flight registers go back to the head, oldest first
    task automatic restore_model();
        for (int i = fly_new.size() - 1; i >= 0; i--) begin
            free_q.push_front(fly_new[i]);
        end
        fly_areg.delete();
        fly_new.delete();
        fly_old.delete();
        spec_map = cmt_map;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the stimulus table finished");
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    end

    initial begin
        logic exp_ready;
        seed   = 45776;
        clear_inputs();
        load_table();
        model_reset();
        wait (arst_n === 1'b1);
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(negedge clk);
            drive_row(stim[r]);
            #1;
            check_count("o_free_count", free_count, fl_count_t'(free_q.size()));
            exp_ready = (free_q.size() >= lanes_in(ren_mask)) && !resteer;
            if (exp_ready !== stim[r].ready) begin
                fail_run($sformatf("table row %0d expects ready %0b but the model gives %0b",
                                   r, stim[r].ready, exp_ready));
            end
            check_ready("o_ren_ready", ren_ready, stim[r].ready);
            case (stim[r].op)
                OP_REN, OP_RND: begin
                    if (stim[r].ready) begin
                        rename_and_check();
                    end
                end
                OP_CMT: retire_commit();
                OP_RST: restore_model();
                default: ;
            endcase
        end
        @(negedge clk);
        clear_inputs();
        #1;
        check_count("o_free_count", free_count, fl_count_t'(free_q.size()));
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: testbench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic o_arst_n
);
    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        o_arst_n = 1'b1;
    end

endmodule

// File: testbench/rename_unit_properties.sv
`timescale 1ns/1ps

module rename_unit_properties import rename_pkg::*; (
    input logic      clk,
    input logic      i_arst_n,
    input logic      i_ren_vld,
    input ren_mask_t i_ren_mask,
    input cmt_mask_t i_cmt_mask,
    input logic      i_resteer,
    input logic      i_ren_ready,
    input fl_count_t i_free_count
);

    // lanes fill from lane 0 with no gaps
    ren_mask_contiguous: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_ren_vld |-> ((i_ren_mask & ren_mask_t'(i_ren_mask + 1'b1)) == '0)
    ) else $error("rename mask has a gap");

    cmt_mask_contiguous: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (i_cmt_mask & cmt_mask_t'(i_cmt_mask + 1'b1)) == '0
    ) else $error("commit mask has a gap");

    free_count_in_range: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_free_count <= fl_count_t'(FL_DEPTH)
    ) else $error("free count above the free list depth");

    no_commit_on_resteer: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_resteer |-> (i_cmt_mask == '0)
    ) else $error("commit in the same cycle as a resteer");

    // a refused group leaves the pool untouched
    refused_group_no_alloc: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (i_ren_vld && !i_ren_ready && !i_resteer && (i_cmt_mask == '0))
            |=> $stable(i_free_count)
    ) else $error("free count changed after a refused rename group");

endmodule

// File: src/rename_unit.sv
`timescale 1ns/1ps

module rename_unit import rename_pkg::*; (
    input  logic      clk,
    input  logic      i_arst_n,
    // rename side
    input  logic      i_ren_vld,
    input  ren_mask_t i_ren_mask,
    input  areg_t     i_ren_areg [REN_WIDTH],
    output logic      o_ren_ready,
    output preg_t     o_ren_preg [REN_WIDTH],
    output preg_t     o_ren_old_preg [REN_WIDTH],
    // commit side
    input  cmt_mask_t i_cmt_mask,
    input  areg_t     i_cmt_areg [CMT_WIDTH],
    input  preg_t     i_cmt_preg [CMT_WIDTH],
    input  preg_t     i_cmt_old_preg [CMT_WIDTH],
    input  logic      i_resteer,
    output fl_count_t o_free_count
);
    fl_count_t req_num;
    fl_count_t free_count;
    logic      ren_fire;

    count_one #(
        .WIDTH (REN_WIDTH)
    ) u_req_cnt (
        .i_a   (i_ren_mask),
        .o_sum (req_num)
    );

    // whole group or nothing
    assign o_ren_ready = (free_count >= req_num) && !i_resteer;
    assign ren_fire    = i_ren_vld && o_ren_ready;

    free_list u_free_list (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_alloc_req  (ren_fire),
        .i_alloc_mask (i_ren_mask),
        .o_alloc_preg (o_ren_preg),
        .o_free_count (free_count),
        .i_rel_mask   (i_cmt_mask),
        .i_rel_preg   (i_cmt_old_preg),
        .i_resteer    (i_resteer)
    );

    assign o_free_count = free_count;

    // new registers come straight from the free list head
    rename_map u_rename_map (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_ren_fire (ren_fire),
        .i_ren_mask (i_ren_mask),
        .i_ren_areg (i_ren_areg),
        .i_new_preg (o_ren_preg),
        .o_old_preg (o_ren_old_preg),
        .i_cmt_mask (i_cmt_mask),
        .i_cmt_areg (i_cmt_areg),
        .i_cmt_preg (i_cmt_preg),
        .i_resteer  (i_resteer)
    );

endmodule

// File: src/rename_map.sv
`timescale 1ns/1ps

module rename_map import rename_pkg::*; (
    input  logic      clk,
    input  logic      i_arst_n,
    input  logic      i_ren_fire,
    input  ren_mask_t i_ren_mask,
    input  areg_t     i_ren_areg [REN_WIDTH],
    input  preg_t     i_new_preg [REN_WIDTH],
    output preg_t     o_old_preg [REN_WIDTH],
    input  cmt_mask_t i_cmt_mask,
    input  areg_t     i_cmt_areg [CMT_WIDTH],
    input  preg_t     i_cmt_preg [CMT_WIDTH],
    input  logic      i_resteer
);
    preg_t spec_map [AREG_NUM];
    preg_t cmt_map  [AREG_NUM];

    // old mapping, with bypass from earlier lanes of the same group
    always_comb begin
        for (int i = 0; i < REN_WIDTH; i++) begin
            o_old_preg[i] = spec_map[i_ren_areg[i]];
            // scanning upward leaves the newest earlier match
            for (int j = 0; j < i; j++) begin
                if (i_ren_mask[j] && (i_ren_areg[j] == i_ren_areg[i])) begin
                    o_old_preg[i] = i_new_preg[j];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int r = 0; r < AREG_NUM; r++) begin
                spec_map[r] <= preg_t'(r);
            end
        end else if (i_resteer) begin
            spec_map <= cmt_map;
        end else if (i_ren_fire) begin
            // later lanes overwrite earlier ones
            for (int i = 0; i < REN_WIDTH; i++) begin
                if (i_ren_mask[i]) begin
                    spec_map[i_ren_areg[i]] <= i_new_preg[i];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int r = 0; r < AREG_NUM; r++) begin
                cmt_map[r] <= preg_t'(r);
            end
        end else begin
            for (int i = 0; i < CMT_WIDTH; i++) begin
                if (i_cmt_mask[i]) begin
                    cmt_map[i_cmt_areg[i]] <= i_cmt_preg[i];
                end
            end
        end
    end

endmodule

// File: src/free_list.sv
`timescale 1ns/1ps

module free_list import rename_pkg::*; (
    input  logic      clk,
    input  logic      i_arst_n,
    input  logic      i_alloc_req,
    input  ren_mask_t i_alloc_mask,
    output preg_t     o_alloc_preg [REN_WIDTH],
    output fl_count_t o_free_count,
    input  cmt_mask_t i_rel_mask,
    input  preg_t     i_rel_preg [CMT_WIDTH],
    input  logic      i_resteer
);
    preg_t     fl_mem [FL_DEPTH];

    // speculative state
    fl_ptr_t   rd_ptr;
    fl_ptr_t   wr_ptr;
    fl_count_t count;

    // state as seen by committed instructions only
    fl_ptr_t   cmt_rd_ptr;

    ren_mask_t alloc_vld;
    fl_count_t alloc_num;
    fl_count_t rel_num;
    fl_count_t commit_num;

    // circular increment, no power of two assumed
    function automatic fl_ptr_t ptr_add(fl_ptr_t ptr, int unsigned inc);
        int unsigned sum;
        sum = int'(ptr) + inc;
        if (sum >= FL_DEPTH) begin
            sum = sum - FL_DEPTH;
        end
        return fl_ptr_t'(sum);
    endfunction

    assign alloc_vld = i_alloc_req ? i_alloc_mask : '0;

    count_one #(
        .WIDTH (REN_WIDTH)
    ) u_alloc_cnt (
        .i_a   (alloc_vld),
        .o_sum (alloc_num)
    );

    count_one #(
        .WIDTH (CMT_WIDTH)
    ) u_rel_cnt (
        .i_a   (i_rel_mask),
        .o_sum (rel_num)
    );

    // each committed instruction consumed one entry at rename
    count_one #(
        .WIDTH (CMT_WIDTH)
    ) u_cmt_cnt (
        .i_a   (i_rel_mask),
        .o_sum (commit_num)
    );

    // head entries in lane order
    always_comb begin
        for (int i = 0; i < REN_WIDTH; i++) begin
            o_alloc_preg[i] = fl_mem[ptr_add(rd_ptr, i)];
        end
    end

    assign o_free_count = count;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_mem[i] <= preg_t'(AREG_NUM + i);
            end
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= fl_count_t'(FL_DEPTH);
        end else begin
            // released registers go to the tail
            for (int i = 0; i < CMT_WIDTH; i++) begin
                if (i_rel_mask[i]) begin
                    fl_mem[ptr_add(wr_ptr, i)] <= i_rel_preg[i];
                end
            end
            wr_ptr <= ptr_add(wr_ptr, rel_num);

            if (i_resteer) begin
                rd_ptr <= cmt_rd_ptr;
                // with nothing in flight the whole pool is free
                count  <= fl_count_t'(FL_DEPTH);
            end else begin
                rd_ptr <= ptr_add(rd_ptr, alloc_num);
                count  <= count - alloc_num + rel_num;
            end
        end
    end

    // committed read pointer trails rd_ptr by the in-flight renames
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cmt_rd_ptr <= '0;
        end else begin
            cmt_rd_ptr <= ptr_add(cmt_rd_ptr, commit_num);
        end
    end

endmodule

// File: src/count_one.sv
`timescale 1ns/1ps

module count_one import rename_pkg::*; #(
    parameter int WIDTH = REN_WIDTH
) (
    input  logic [WIDTH-1:0] i_a,
    output fl_count_t        o_sum
);
    localparam int PAIRS = (WIDTH + 1) / 2;

    logic [1:0] pair_sum [PAIRS];

    // first level adds neighbouring bits
    for (genvar p = 0; p < PAIRS; p++) begin : gen_pair
        if (2 * p + 1 < WIDTH) begin : gen_two
            assign pair_sum[p] = {1'b0, i_a[2*p]} + {1'b0, i_a[2*p+1]};
        end else begin : gen_one
            assign pair_sum[p] = {1'b0, i_a[2*p]};
        end
    end

    always_comb begin
        o_sum = '0;
        for (int p = 0; p < PAIRS; p++) begin
            o_sum = o_sum + fl_count_t'(pair_sum[p]);
        end
    end

endmodule

// File: src/rename_pkg.sv
package rename_pkg;

    // lanes per cycle
    localparam int REN_WIDTH = 4;
    localparam int CMT_WIDTH = 4;

    // register file sizes
    localparam int AREG_NUM = 16;
    localparam int PREG_NUM = 48;

    // every physical register not held by the committed map is free
    localparam int FL_DEPTH = PREG_NUM - AREG_NUM;

    typedef logic [$clog2(AREG_NUM)-1:0] areg_t;

    typedef logic [$clog2(PREG_NUM)-1:0] preg_t;

    typedef logic [REN_WIDTH-1:0] ren_mask_t;

    typedef logic [CMT_WIDTH-1:0] cmt_mask_t;

    typedef logic [$clog2(FL_DEPTH)-1:0] fl_ptr_t;

    // needs one extra bit to hold a full count
    typedef logic [$clog2(FL_DEPTH+1)-1:0] fl_count_t;

endpackage
